// File: hw/snd_pkg.sv
// sound board shared definitions
// widths, typedefs, sequencer states and rate constants

package snd_pkg;

    // bus and register widths
    typedef logic [7:0]  cmd_t;          // command byte from main cpu
    typedef logic [14:0] rom_addr_t;     // 32 kB sound rom
    typedef logic [2:0]  reg_sel_t;      // synth register select
    typedef logic [11:0] period_t;       // half period in sample ticks, minus one
    typedef logic [3:0]  vol_t;
    typedef logic signed [15:0] sample_t;

    // fractional enable, same ratio as the fm clock enable
    localparam int frac_w = 10;
    typedef logic [frac_w-1:0] frac_t;
    localparam frac_t frac_n = 10'd105;
    localparam frac_t frac_m = 10'd704;

    // script layout in rom
    localparam int script_shift = 7;     // cmd*128
    localparam int script_max   = 64;    // pairs per script, hard stop
    localparam int pair_w       = $clog2(script_max);
    localparam logic [7:0] end_mark = 8'hff;

    // voice level scaling
    localparam int amp_shift = 8;

    // sequencer states
    typedef enum logic [2:0] {
        idle,        // waiting for a pending command
        fetch_reg,   // reading register byte
        fetch_data,  // reading data byte
        write,       // one cycle write strobe
        done         // script over, back to idle
    } seq_state_t;

endpackage

// File: hw/snd_frac_cen.sv
// fractional clock enable
// pulses frac_n times every frac_m clocks, sets the synth sample rate

`timescale 1ns/1ps

module snd_frac_cen (
    input  logic clk,
    input  logic arst_n,
    output logic cen_fm
);
    import snd_pkg::*;

    frac_t acc;      // modular phase accumulator
    frac_t acc_sum;  // acc + n, worst case 808 so no overflow in 10 bits
    logic  wrap;

    assign acc_sum = acc + frac_n;
    assign wrap    = acc_sum >= frac_m;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= '0;
            cen_fm <= 1'b0;
        end else begin
            if (wrap) begin
                acc <= acc_sum - frac_m;   // keep the remainder
            end else begin
                acc <= acc_sum;
            end
            cen_fm <= wrap;    // one clock pulse per wrap
        end
    end

    // n/m well below 1/2, so a wrap can never repeat on the next clock
    a_cen_single : assert property (
        @(posedge clk) disable iff (!arst_n)
        cen_fm |=> !cen_fm
    ) else $error("cen_fm high on two cycles in a row");

endmodule

// File: hw/snd_seq.sv
// command sequencer
// latches the main cpu command on an irq edge, then walks the matching
// rom script and turns register/data byte pairs into synth write strobes

`timescale 1ns/1ps

module snd_seq (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cen3,
    input  logic               snd_irq,
    input  snd_pkg::cmd_t      snd_latch,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    output logic               wr,
    output snd_pkg::reg_sel_t  reg_sel,
    output logic [7:0]         wdata
);
    import snd_pkg::*;

    seq_state_t st;
    logic       irq_q;       // previous irq level
    logic       irq_edge;
    logic       pending;     // command waiting for the sequencer
    cmd_t       cmd_q;       // last latched command
    rom_addr_t  addr;
    logic [pair_w-1:0] pair_cnt;
    logic       start;
    logic       rd_ok;       // rom byte accepted this cycle
    logic       last_pair;

    assign irq_edge  = snd_irq & ~irq_q;
    assign start     = (st == idle) && pending && cen3;
    assign rd_ok     = rom_cs && rom_ok && cen3;
    assign last_pair = pair_cnt == pair_w'(script_max - 1);

    assign rom_cs   = (st == fetch_reg) || (st == fetch_data);
    assign rom_addr = addr;
    assign wr       = st == write;   // write state lasts a single cycle

    // irq edge capture and command latch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_q   <= 1'b0;
            pending <= 1'b0;
            cmd_q   <= '0;
        end else begin
            irq_q <= snd_irq;
            if (irq_edge) begin
                pending <= 1'b1;        // a new edge wins over a start
                cmd_q   <= snd_latch;   // later edge overwrites
            end else if (start) begin
                pending <= 1'b0;
            end
        end
    end

    // script walker
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st       <= idle;
            addr     <= '0;
            pair_cnt <= '0;
            reg_sel  <= '0;
            wdata    <= '0;
        end else begin
            case (st)
                idle: begin
                    if (start) begin
                        addr     <= rom_addr_t'(cmd_q) << script_shift;
                        pair_cnt <= '0;
                        st       <= fetch_reg;
                    end
                end
                fetch_reg: begin
                    if (rd_ok) begin
                        if (rom_data == end_mark) begin
                            st <= done;          // terminator, no write
                        end else begin
                            reg_sel <= rom_data[2:0];
                            addr    <= addr + 1'b1;
                            st      <= fetch_data;
                        end
                    end
                end
                fetch_data: begin
                    if (rd_ok) begin
                        wdata <= rom_data;
                        addr  <= addr + 1'b1;
                        st    <= write;
                    end
                end
                write: begin
                    pair_cnt <= pair_cnt + 1'b1;
                    // runaway scripts stop at script_max pairs
                    st <= last_pair ? done : fetch_reg;
                end
                done: begin
                    st <= idle;   // pending edges served from here
                end
                default: st <= idle;
            endcase
        end
    end

    // rom port must hold its address until the byte is delivered
    a_addr_hold : assert property (
        @(posedge clk) disable iff (!arst_n)
        rom_cs && !rom_ok |=> $stable(rom_addr)
    ) else $error("rom_addr moved during a pending fetch");

    a_wr_no_fetch : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wr && rom_cs)
    ) else $error("wr overlaps a rom fetch");

endmodule

// File: hw/snd_voice.sv
// square-wave voice
// period, volume and pan registers, half-period down-counter and phase

`timescale 1ns/1ps

module snd_voice #(
    parameter int voice_idx = 0     // picks register group 0..2 or 3..5
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cen_fm,
    input  logic              wr,
    input  snd_pkg::reg_sel_t reg_sel,
    input  logic [7:0]        wdata,
    output snd_pkg::sample_t  amp,
    output logic              pan_l,
    output logic              pan_r
);
    import snd_pkg::*;

    localparam reg_sel_t base = reg_sel_t'(voice_idx * 3);

    period_t period;     // reload value
    period_t cnt;        // ticks left in this half period
    vol_t    vol;
    logic    phase;      // high half or low half
    sample_t mag;

    // register writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            period <= '0;
            vol    <= '0;
            pan_l  <= 1'b0;
            pan_r  <= 1'b0;
        end else if (wr) begin
            if (reg_sel == base) begin
                period[7:0] <= wdata;          // period low
            end
            if (reg_sel == base + 3'd1) begin
                period[11:8] <= wdata[3:0];    // period high
            end
            if (reg_sel == base + 3'd2) begin
                vol   <= wdata[3:0];
                pan_l <= wdata[4];
                pan_r <= wdata[5];
            end
        end
    end

    // tone generator, phase lasts period+1 ticks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= '0;
            phase <= 1'b0;
        end else if (cen_fm) begin
            if (cnt == '0) begin
                cnt   <= period;
                phase <= ~phase;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign mag = sample_t'(vol) <<< amp_shift;   // max 3840
    assign amp = phase ? mag : -mag;             // zero volume gives zero

endmodule

// File: hw/snd_mixer.sv
// stereo mixer
// gates voices by pan, sums per side with +6 dB gain and registers the
// result on the sample tick, strobing sample on the following cycle

`timescale 1ns/1ps

module snd_mixer (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen_fm,
    input  snd_pkg::sample_t amp0,
    input  snd_pkg::sample_t amp1,
    input  logic             pan_l0,
    input  logic             pan_r0,
    input  logic             pan_l1,
    input  logic             pan_r1,
    output snd_pkg::sample_t snd_left,
    output snd_pkg::sample_t snd_right,
    output logic             sample
);
    import snd_pkg::*;

    sample_t l0, l1, r0, r1;   // pan gated voices
    sample_t sum_l, sum_r;

    assign l0 = pan_l0 ? amp0 : '0;
    assign l1 = pan_l1 ? amp1 : '0;
    assign r0 = pan_r0 ? amp0 : '0;
    assign r1 = pan_r1 ? amp1 : '0;

    // two voices top out at 7680, doubled still fits 16 bits
    assign sum_l = l0 + l1;
    assign sum_r = r0 + r1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
        end else begin
            if (cen_fm) begin
                snd_left  <= sum_l <<< 1;   // +6 dB
                snd_right <= sum_r <<< 1;
            end
            sample <= cen_fm;   // new values visible with the strobe
        end
    end

    a_sample_pulse : assert property (
        @(posedge clk) disable iff (!arst_n)
        sample |=> !sample
    ) else $error("sample strobe longer than one cycle");

endmodule

// File: hw/snd_board.sv
// arcade sound board top
// command sequencer driving a two-voice square synth with stereo mixer

`timescale 1ns/1ps

module snd_board (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cen3,       // sequencer step enable
    input  logic               snd_irq,    // edge from main cpu
    input  snd_pkg::cmd_t      snd_latch,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    output snd_pkg::sample_t   snd_left,
    output snd_pkg::sample_t   snd_right,
    output logic               sample
);
    import snd_pkg::*;

    logic       cen_fm;      // synth sample tick
    logic       wr;
    reg_sel_t   reg_sel;
    logic [7:0] wdata;
    sample_t    amp0, amp1;
    logic       pan_l0, pan_r0, pan_l1, pan_r1;

    snd_frac_cen u_fmcen (.clk(clk), .arst_n(arst_n), .cen_fm(cen_fm));

    snd_seq u_seq (
        .clk     (clk),       .arst_n  (arst_n),
        .cen3    (cen3),      .snd_irq (snd_irq),
        .snd_latch(snd_latch),
        .rom_data(rom_data),  .rom_ok  (rom_ok),
        .rom_addr(rom_addr),  .rom_cs  (rom_cs),
        .wr      (wr),        .reg_sel (reg_sel),
        .wdata   (wdata)
    );

    snd_voice #(.voice_idx(0)) u_voice0 (
        .clk  (clk),   .arst_n (arst_n), .cen_fm(cen_fm),
        .wr   (wr),    .reg_sel(reg_sel), .wdata (wdata),
        .amp  (amp0),  .pan_l  (pan_l0),  .pan_r (pan_r0)
    );

    snd_voice #(.voice_idx(1)) u_voice1 (
        .clk  (clk),   .arst_n (arst_n), .cen_fm(cen_fm),
        .wr   (wr),    .reg_sel(reg_sel), .wdata (wdata),
        .amp  (amp1),  .pan_l  (pan_l1),  .pan_r (pan_r1)
    );

    snd_mixer u_mixer (
        .clk    (clk),    .arst_n   (arst_n),   .cen_fm(cen_fm),
        .amp0   (amp0),   .amp1     (amp1),
        .pan_l0 (pan_l0), .pan_r0   (pan_r0),
        .pan_l1 (pan_l1), .pan_r1   (pan_r1),
        .snd_left(snd_left), .snd_right(snd_right), .sample(sample)
    );

endmodule

// File: verification/snd_tb.sv
// sound board testbench
// random rom scripts behind a rom responder with random wait states,
// a model of the script walk, voice levels and stereo sums

`timescale 1ns/1ps

module snd_tb;
    import snd_pkg::*;

    localparam int n_rand     = 8;      // random commands in the walk test
    localparam int n_scripts  = n_rand + 8;
    localparam int script_cyc = 256;    // room for a 21 read script
    localparam int sample_cyc = 7;      // 704/105 rounded up
    localparam int rate_win   = 7040;   // ten full enable periods
    localparam int cyc_limit  = 4 * (11 + rate_win + n_scripts * (script_cyc + 72)
                                     + 400 * sample_cyc);

    logic       clk;
    logic       arst_n;
    logic       cen3;
    logic       snd_irq;
    cmd_t       snd_latch;
    logic [7:0] rom_data;
    logic       rom_ok;
    rom_addr_t  rom_addr;
    logic       rom_cs;
    sample_t    snd_left;
    sample_t    snd_right;
    logic       sample;

    logic [7:0] rom [0:32767];   // sound rom model
    int acc_q[$];                // addresses the dut took
    int exp_q[$];                // addresses the model predicts
    int lq[$];
    int rq[$];
    int cyc;                     // stimulus cycle, cen3 phase
    int run_cyc = 0;             // watchdog
    int n_checks;
    int n_errors;
    logic busy;                  // rom fetch in flight
    int cur_addr;
    int wait_left;               // wait states left on this fetch

    snd_board dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .cen3     (cen3),
        .snd_irq  (snd_irq),
        .snd_latch(snd_latch),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .snd_left (snd_left),
        .snd_right(snd_right),
        .sample   (sample)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns
    end

    always @(posedge clk) begin
        run_cyc = run_cyc + 1;
        if (run_cyc > cyc_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", run_cyc);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed, %0d mismatches", name, n_errors - errs_before);
        end
    endtask

    // one clock with cen3, rom answer and accept log set on the falling edge
    task automatic tick();
        @(negedge clk);
        cyc  = cyc + 1;
        cen3 = (cyc % 4) == 0;
        if (rom_cs) begin
            if (!busy || rom_addr != cur_addr) begin   // new fetch
                busy      = 1'b1;
                cur_addr  = rom_addr;
                wait_left = $urandom % 6;
            end
            rom_data = rom[rom_addr];
            rom_ok   = wait_left == 0;
            if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end
        end else begin
            busy   = 1'b0;
            rom_ok = 1'b0;
        end
        if (rom_cs && rom_ok && cen3) begin
            acc_q.push_back(rom_addr);   // taken at the next rising edge
        end
    endtask

    task automatic pulse_irq(input int cmd);
        snd_irq   = 1'b1;
        snd_latch = cmd_t'(cmd);
        tick();
        snd_irq = 1'b0;   // one cycle high gives one edge
    endtask

    task automatic put_pair(inout int a, input int r, input int d);
        rom[a]     = 8'(r);
        rom[a + 1] = 8'(d);
        a = a + 2;
    endtask

    task automatic fill_rom();
        int a;
        int n;
        for (int i = 0; i < 32768; i++) begin
            rom[i] = 8'(i ^ (i >> 7));   // low byte xor high bits
        end
        for (int c = 0; c < 256; c++) begin
            a = c * 128;
            n = 1 + $urandom % 10;
            for (int p = 0; p < n; p++) begin
                put_pair(a, $urandom % 6, $urandom % 256);
            end
            rom[a] = end_mark;
        end
    endtask

    // model of the script walk over register and data bytes up to the terminator
    task automatic expect_script(input int cmd);
        int addr;
        int pairs;
        bit stop;
        addr  = cmd * 128;
        pairs = 0;
        stop  = 0;
        while (!stop) begin
            exp_q.push_back(addr);
            if (rom[addr] == end_mark) begin
                stop = 1;
            end else begin
                exp_q.push_back(addr + 1);
                addr  = addr + 2;
                pairs = pairs + 1;
                stop  = pairs == script_max;   // hard stop without a terminator read
            end
        end
    endtask

    task automatic compare_walk();
        check(acc_q.size(), exp_q.size(), "accepted rom reads");
        for (int i = 0; i < exp_q.size() && i < acc_q.size(); i++) begin
            check(acc_q[i], exp_q[i], "rom address");
        end
        acc_q.delete();
        exp_q.delete();
    endtask

    task automatic run_script(input int cmd);
        expect_script(cmd);
        pulse_irq(cmd);
        while (acc_q.size() < exp_q.size()) begin
            tick();
        end
        repeat (8) tick();   // room for a stray read
        compare_walk();
    endtask

    // gather n sample pulses after skipping two that may hold the old setting
    task automatic collect(input int n);
        int skipped;
        skipped = 0;
        lq.delete();
        rq.delete();
        while (lq.size() < n) begin
            tick();
            if (sample && skipped < 2) begin
                skipped++;
            end else if (sample) begin
                lq.push_back(int'(snd_left));
                rq.push_back(int'(snd_right));
            end
        end
    endtask

    task automatic idle_after_reset();
        int errs;
        int n_samp;
        errs = n_errors;
        check(rom_cs, 0, "rom_cs in reset");
        check(sample, 0, "sample in reset");
        check(snd_left, 0, "left in reset");
        check(snd_right, 0, "right in reset");
        arst_n = 1'b1;
        tick();   // sample trails the enable by one clock
        n_samp = 0;
        for (int i = 0; i < rate_win; i++) begin
            tick();
            check(rom_cs, 0, "rom_cs with no command");
            if (sample) begin
                n_samp++;
                check(snd_left, 0, "left before any volume");
                check(snd_right, 0, "right before any volume");
            end
        end
        report_test("reset state", errs);
        errs = n_errors;
        check(n_samp, rate_win * int'(frac_n) / int'(frac_m), "sample pulses");
        report_test("sample rate", errs);
    endtask

    task automatic play_single_voice();
        int errs;
        int cmd;
        int a;
        int per;
        int vol;
        int mag;
        int first;   // index of the first phase flip
        int sgn;
        int exp_v;
        errs = n_errors;
        per  = 1 + $urandom % 20;
        vol  = 1 + $urandom % 15;
        cmd  = $urandom % 256;
        a    = cmd * 128;
        put_pair(a, 0, per);          // period low
        put_pair(a, 1, 0);            // period high
        put_pair(a, 2, 8'h30 | vol);  // both sides
        put_pair(a, 5, 0);            // voice 1 silent
        rom[a] = end_mark;
        run_script(cmd);
        collect(200);
        mag   = 2 * (vol << amp_shift);
        first = -1;
        sgn   = 1;
        for (int i = 0; i < lq.size(); i++) begin
            check(int'(lq[i] == mag || lq[i] == -mag), 1, "voice 0 level");
            if (first < 0 && i > 0 && lq[i] != lq[i - 1]) begin
                first = i;                    // partial first run ends here
                sgn   = (lq[i] > 0) ? 1 : -1;
            end
            if (first >= 0) begin
                // square wave flips every per+1 samples from the first flip
                exp_v = ((((i - first) / (per + 1)) % 2) == 0) ? sgn * mag : -sgn * mag;
                check(lq[i], exp_v, "left half period");
                check(rq[i], exp_v, "right half period");
            end else begin
                check(int'(rq[i] == mag || rq[i] == -mag), 1, "voice 0 right level");
            end
        end
        check(int'(first >= 0 && lq.size() - first > 2 * (per + 1)), 1, "voice 0 toggles");
        report_test("single voice", errs);
    endtask

    task automatic play_two_voices();
        int errs;
        int cmd;
        int a;
        int vol0, vol1, pan0, pan1;
        int a0, a1, exp_l, exp_r;
        int found;
        errs = n_errors;
        for (int k = 0; k < 3; k++) begin
            vol0 = 1 + $urandom % 15;
            vol1 = 1 + $urandom % 15;
            pan0 = $urandom % 4;   // bit 0 left, bit 1 right
            pan1 = $urandom % 4;
            if (k == 0) begin
                pan0 = pan0 & 1;   // nothing routed to the right side
                pan1 = pan1 & 1;
            end else if (k == 1) begin
                pan0 = 3;          // both voices summed on both sides
                pan1 = 3;
            end
            cmd  = $urandom % 256;
            a    = cmd * 128;
            put_pair(a, 0, 1 + $urandom % 20);
            put_pair(a, 1, 0);
            put_pair(a, 2, (pan0 << 4) | vol0);
            put_pair(a, 3, 1 + $urandom % 20);
            put_pair(a, 4, 0);
            put_pair(a, 5, (pan1 << 4) | vol1);
            rom[a] = end_mark;
            run_script(cmd);
            collect(64);
            for (int i = 0; i < lq.size(); i++) begin
                found = 0;
                for (int s = 0; s < 4; s++) begin   // both phase signs per voice
                    a0    = s[0] ? (vol0 << amp_shift) : -(vol0 << amp_shift);
                    a1    = s[1] ? (vol1 << amp_shift) : -(vol1 << amp_shift);
                    exp_l = 2 * ((pan0[0] ? a0 : 0) + (pan1[0] ? a1 : 0));
                    exp_r = 2 * ((pan0[1] ? a0 : 0) + (pan1[1] ? a1 : 0));
                    if (lq[i] == exp_l && rq[i] == exp_r) begin
                        found = 1;
                    end
                end
                check(found, 1, "stereo sum of panned voices");
            end
        end
        report_test("two voices", errs);
    endtask

    task automatic walk_random_scripts();
        int errs;
        errs = n_errors;
        for (int k = 0; k < n_rand; k++) begin
            run_script($urandom % 256);
        end
        report_test("script walk", errs);
    endtask

    task automatic order_irq_edges();
        int errs;
        int c0;
        int c1;
        errs = n_errors;
        c0 = $urandom % 256;
        c1 = $urandom % 256;
        expect_script(c0);
        expect_script(c1);
        pulse_irq(c0);
        while (acc_q.size() == 0) begin
            tick();   // first script under way
        end
        pulse_irq(c1);
        while (acc_q.size() < exp_q.size()) begin
            tick();
        end
        repeat (64) tick();
        compare_walk();
        // two edges in one cen3 gap leave only the second to run
        c0 = $urandom % 256;
        c1 = (c0 + 1 + $urandom % 255) % 256;
        expect_script(c1);
        while (cyc % 4 != 1) begin
            tick();
        end
        pulse_irq(c0);
        tick();
        pulse_irq(c1);   // lands just before the cen3 cycle
        while (acc_q.size() < exp_q.size()) begin
            tick();
        end
        repeat (64) tick();
        compare_walk();
        report_test("irq ordering", errs);
    endtask

    initial begin
        arst_n    = 1'b0;
        cen3      = 1'b0;
        snd_irq   = 1'b0;
        snd_latch = '0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        cyc       = 0;
        busy      = 1'b0;
        cur_addr  = 0;
        wait_left = 0;
        n_checks  = 0;
        n_errors  = 0;
        void'($urandom(32'h7fd9));
        fill_rom();
        repeat (10) tick();   // reset held 10 cycles
        idle_after_reset();
        play_single_voice();   // before random scripts load long periods
        play_two_voices();
        walk_random_scripts();
        order_irq_edges();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: build.f
hw/snd_pkg.sv
hw/snd_frac_cen.sv
hw/snd_seq.sv
hw/snd_voice.sv
hw/snd_mixer.sv
hw/snd_board.sv
verification/snd_tb.sv

// File: Makefile
# verilator build and run of the sound board testbench

SRCS := $(shell cat build.f)

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vsnd_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module snd_tb -o Vsnd_tb

# the log decides pass or fail
run: obj_dir/Vsnd_tb
	./obj_dir/Vsnd_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
